// File: logic/hemaia_map_pkg.sv
// Address map and bus widths of the memory chip fabric.
// Offsets are relative to the 40-bit local space below the chip ID byte.
// The memory window is cut down to 4 KiB, and the DRAM range is not mapped.

`default_nettype none

package hemaia_map_pkg;

  // Bus widths
  localparam int unsigned AddrWidth   = 48;
  localparam int unsigned ChipIdWidth = 8;
  localparam int unsigned LocalWidth  = 40;
  localparam int unsigned DataWidth   = 32;

  //////////////////////////////////////////////////
  // Memory window
  //////////////////////////////////////////////////

  localparam logic [LocalWidth-1:0] MemBase  = 40'h00_8000_0000;
  localparam logic [LocalWidth-1:0] MemSize  = 40'h00_0000_1000;
  localparam int unsigned           MemWords = 1024;

  //////////////////////////////////////////////////
  // Register window
  //////////////////////////////////////////////////

  localparam logic [LocalWidth-1:0] PeriphBase = 40'h00_0200_5000;
  localparam logic [LocalWidth-1:0] PeriphSize = 40'h00_0000_1000;

  // Offsets inside the register window
  localparam logic [LocalWidth-1:0] RegDivOffset    = 40'h0;
  localparam logic [LocalWidth-1:0] RegChipIdOffset = 40'h4;

  // Where the router sends a request
  typedef enum logic [1:0] {
    TGT_MEM,
    TGT_PERIPH,
    TGT_ERR
  } target_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_RESP
  } router_state_e;

endpackage

`default_nettype wire

// File: logic/hemaia_clk_pkg.sv
// Tick divisor and reset delay of the memory bank.
// A divisor of 0 never reaches the controller, the register block stores it as 1.

`default_nettype none

package hemaia_clk_pkg;

  localparam int unsigned DivWidth = 8;

  // Divisor after reset
  localparam logic [DivWidth-1:0] DefaultDivision = DivWidth'(4);

  // Memory ticks the bank stays in reset
  localparam logic [DivWidth-1:0] ResetDelay = DivWidth'(3);

endpackage

`default_nettype wire

// File: logic/hemaia_bus_if.sv
// Request/response link between the router and one target.
// Valid/ready on the request, a one-cycle rsp_valid pulse on the response.
// The offset is the window-relative byte address.

`timescale 1ns/1ps
`default_nettype none

interface hemaia_bus_if;

  // Request side
  logic                                  req_valid;
  logic                                  req_ready;
  logic                                  write;
  logic [hemaia_map_pkg::LocalWidth-1:0] offset;
  logic [hemaia_map_pkg::DataWidth-1:0]  wdata;

  // Response side, no back-pressure
  logic                                  rsp_valid;
  logic [hemaia_map_pkg::DataWidth-1:0]  rdata;
  logic                                  error;

  modport requester (
    output req_valid, write, offset, wdata,
    input  req_ready, rsp_valid, rdata, error
  );

  modport completer (
    input  req_valid, write, offset, wdata,
    output req_ready, rsp_valid, rdata, error
  );

endinterface

`default_nettype wire

// File: logic/hemaia_clk_rst_ctrl.sv
// Memory tick and bank reset, all on clk_i.
// The tick is a one-cycle strobe, not a generated clock.
// A new divisor is taken at the next wrap. division_i must not be 0.

`timescale 1ns/1ps
`default_nettype none

module hemaia_clk_rst_ctrl (
  input  wire logic                                clk_i,
  input  wire logic                                rst_ni,
  input  wire logic [hemaia_clk_pkg::DivWidth-1:0] division_i,
  output logic                                     mem_tick_o,
  output logic                                     mem_rst_no
);

  logic [hemaia_clk_pkg::DivWidth-1:0] cnt_q;
  logic [hemaia_clk_pkg::DivWidth-1:0] div_q;
  logic [hemaia_clk_pkg::DivWidth-1:0] rst_cnt_q;
  logic                                tick_q;
  logic                                wrap;

  //////////////////////////////////////////////////
  // Tick divider
  //////////////////////////////////////////////////

  assign wrap = (cnt_q == div_q - hemaia_clk_pkg::DivWidth'(1));

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cnt_q  <= '0;
      div_q  <= hemaia_clk_pkg::DefaultDivision;
      tick_q <= 1'b0;
    end else begin
      tick_q <= wrap;
      if (wrap) begin
        cnt_q <= '0;
        // Divisor only changes on a period boundary
        div_q <= division_i;
      end else begin
        cnt_q <= cnt_q + hemaia_clk_pkg::DivWidth'(1);
      end
    end
  end

  assign mem_tick_o = tick_q;

  //////////////////////////////////////////////////
  // Bank reset release
  //////////////////////////////////////////////////

  // Count ticks until the delay is reached, then hold
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rst_cnt_q <= '0;
    end else if (tick_q && !mem_rst_no) begin
      rst_cnt_q <= rst_cnt_q + hemaia_clk_pkg::DivWidth'(1);
    end
  end

  assign mem_rst_no = (rst_cnt_q == hemaia_clk_pkg::ResetDelay);

endmodule

`default_nettype wire

// File: logic/hemaia_addr_router.sv
// Routes one request at a time to the memory bank, the registers or an error.
// The chip ID is sampled on every clock while rst_ni is low.
// Unmatched addresses get error 1 and rdata 0 one cycle after acceptance.

`timescale 1ns/1ps
`default_nettype none

module hemaia_addr_router (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_ni,
  input  wire logic [hemaia_map_pkg::ChipIdWidth-1:0] chip_id_i,
  input  wire logic                                   req_valid_i,
  input  wire logic                                   req_write_i,
  input  wire logic [hemaia_map_pkg::AddrWidth-1:0]   req_addr_i,
  input  wire logic [hemaia_map_pkg::DataWidth-1:0]   req_wdata_i,
  output logic                                        req_ready_o,
  output logic                                        rsp_valid_o,
  output logic      [hemaia_map_pkg::DataWidth-1:0]   rsp_rdata_o,
  output logic                                        rsp_error_o,
  output logic      [hemaia_map_pkg::ChipIdWidth-1:0] chip_id_o,
  hemaia_bus_if.requester                             mem_bus,
  hemaia_bus_if.requester                             periph_bus
);

  hemaia_map_pkg::router_state_e         state_q, state_d;
  hemaia_map_pkg::target_e               tgt_q, tgt_d;
  logic [hemaia_map_pkg::ChipIdWidth-1:0] chip_id_q;
  logic [hemaia_map_pkg::ChipIdWidth-1:0] req_chip;
  logic [hemaia_map_pkg::LocalWidth-1:0]  req_local;
  logic [hemaia_map_pkg::LocalWidth-1:0]  offset_q;
  logic [hemaia_map_pkg::DataWidth-1:0]   wdata_q;
  logic [hemaia_map_pkg::DataWidth-1:0]   tgt_rdata;
  logic                                   write_q;
  logic                                   sent_q;
  logic                                   accept;
  logic                                   fwd_valid;
  logic                                   tgt_ready;
  logic                                   tgt_rsp_valid;
  logic                                   tgt_error;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      chip_id_q <= chip_id_i;
    end
  end

  assign chip_id_o = chip_id_q;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  assign req_chip  = req_addr_i[hemaia_map_pkg::AddrWidth-1 -: hemaia_map_pkg::ChipIdWidth];
  assign req_local = req_addr_i[hemaia_map_pkg::LocalWidth-1:0];
  assign accept    = req_valid_i && req_ready_o;

  always_comb begin
    tgt_d = hemaia_map_pkg::TGT_ERR;
    if (req_chip == chip_id_q) begin
      if (req_local >= hemaia_map_pkg::MemBase &&
          req_local < hemaia_map_pkg::MemBase + hemaia_map_pkg::MemSize) begin
        tgt_d = hemaia_map_pkg::TGT_MEM;
      end else if (req_local >= hemaia_map_pkg::PeriphBase &&
                   req_local < hemaia_map_pkg::PeriphBase + hemaia_map_pkg::PeriphSize) begin
        tgt_d = hemaia_map_pkg::TGT_PERIPH;
      end
    end
  end

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      hemaia_map_pkg::ST_IDLE: begin
        if (accept) begin
          state_d = (tgt_d == hemaia_map_pkg::TGT_ERR) ? hemaia_map_pkg::ST_RESP
                                                       : hemaia_map_pkg::ST_WAIT;
        end
      end
      hemaia_map_pkg::ST_WAIT: if (tgt_rsp_valid) state_d = hemaia_map_pkg::ST_IDLE;
      hemaia_map_pkg::ST_RESP: state_d = hemaia_map_pkg::ST_IDLE;
      default: state_d = hemaia_map_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= hemaia_map_pkg::ST_IDLE;
      tgt_q   <= hemaia_map_pkg::TGT_ERR;
      sent_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        tgt_q  <= tgt_d;
        sent_q <= 1'b0;
      end else if (fwd_valid && tgt_ready) begin
        sent_q <= 1'b1;
      end
    end
  end

  // Request fields, rebased into the chosen window
  always_ff @(posedge clk_i) begin
    if (accept) begin
      write_q  <= req_write_i;
      wdata_q  <= req_wdata_i;
      offset_q <= (tgt_d == hemaia_map_pkg::TGT_MEM) ? req_local - hemaia_map_pkg::MemBase
                                                     : req_local - hemaia_map_pkg::PeriphBase;
    end
  end

  //////////////////////////////////////////////////
  // Target side
  //////////////////////////////////////////////////

  // Held until the target takes it
  assign fwd_valid = (state_q == hemaia_map_pkg::ST_WAIT) && !sent_q;

  assign mem_bus.req_valid    = fwd_valid && (tgt_q == hemaia_map_pkg::TGT_MEM);
  assign mem_bus.write        = write_q;
  assign mem_bus.offset       = offset_q;
  assign mem_bus.wdata        = wdata_q;
  assign periph_bus.req_valid = fwd_valid && (tgt_q == hemaia_map_pkg::TGT_PERIPH);
  assign periph_bus.write     = write_q;
  assign periph_bus.offset    = offset_q;
  assign periph_bus.wdata     = wdata_q;

  always_comb begin
    if (tgt_q == hemaia_map_pkg::TGT_MEM) begin
      tgt_ready     = mem_bus.req_ready;
      tgt_rsp_valid = mem_bus.rsp_valid;
      tgt_rdata     = mem_bus.rdata;
      tgt_error     = mem_bus.error;
    end else begin
      tgt_ready     = periph_bus.req_ready;
      tgt_rsp_valid = periph_bus.rsp_valid;
      tgt_rdata     = periph_bus.rdata;
      tgt_error     = periph_bus.error;
    end
  end

  assign req_ready_o = (state_q == hemaia_map_pkg::ST_IDLE);
  assign rsp_valid_o = (state_q == hemaia_map_pkg::ST_RESP) ||
                       ((state_q == hemaia_map_pkg::ST_WAIT) && tgt_rsp_valid);
  assign rsp_rdata_o = (state_q == hemaia_map_pkg::ST_WAIT) ? tgt_rdata : '0;
  assign rsp_error_o = (state_q == hemaia_map_pkg::ST_RESP) ||
                       ((state_q == hemaia_map_pkg::ST_WAIT) && tgt_error);

endmodule

`default_nettype wire

// File: logic/hemaia_mem_bank.sv
// Single-port SRAM bank of MemWords words.
// Takes a request only on a memory tick outside bank reset.
// Contents start at zero and are kept through reset.

`timescale 1ns/1ps
`default_nettype none

module hemaia_mem_bank (
  input  wire logic       clk_i,
  input  wire logic       mem_tick_i,
  input  wire logic       mem_rst_ni,
  hemaia_bus_if.completer bus
);

  logic [hemaia_map_pkg::DataWidth-1:0] mem_q [hemaia_map_pkg::MemWords] = '{default: '0};

  logic [$clog2(hemaia_map_pkg::MemWords)-1:0] word_idx;
  logic [hemaia_map_pkg::DataWidth-1:0]        rdata_q;
  logic                                        rsp_valid_q;
  logic                                        accept;

  assign bus.req_ready = mem_tick_i && mem_rst_ni;
  assign accept        = bus.req_valid && bus.req_ready;

  // Byte offset to word index
  assign word_idx = bus.offset[$clog2(hemaia_map_pkg::MemWords)+1:2];

  //////////////////////////////////////////////////
  // Array access
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (bus.write) begin
        mem_q[word_idx] <= bus.wdata;
        rdata_q         <= '0;
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  // Response one cycle after the tick that took the request
  always_ff @(posedge clk_i) begin
    if (!mem_rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= accept;
    end
  end

  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rdata     = rdata_q;
  assign bus.error     = 1'b0;

endmodule

`default_nettype wire

// File: logic/hemaia_periph_regs.sv
// Divisor register and chip ID readback.
// Always ready, answers one cycle later, never signals an error.
// Writing 0 to the divisor stores 1.

`timescale 1ns/1ps
`default_nettype none

module hemaia_periph_regs (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_ni,
  input  wire logic [hemaia_map_pkg::ChipIdWidth-1:0] chip_id_i,
  output logic      [hemaia_clk_pkg::DivWidth-1:0]    division_o,
  hemaia_bus_if.completer                             bus
);

  logic [hemaia_clk_pkg::DivWidth-1:0]  div_q;
  logic [hemaia_clk_pkg::DivWidth-1:0]  div_wr;
  logic [hemaia_map_pkg::DataWidth-1:0] rd_word;
  logic [hemaia_map_pkg::DataWidth-1:0] rdata_q;
  logic                                 rsp_valid_q;
  logic                                 accept;

  assign bus.req_ready = 1'b1;
  assign accept        = bus.req_valid && bus.req_ready;
  assign div_wr        = bus.wdata[hemaia_clk_pkg::DivWidth-1:0];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      div_q       <= hemaia_clk_pkg::DefaultDivision;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= accept;
      if (accept && bus.write && bus.offset == hemaia_map_pkg::RegDivOffset) begin
        div_q <= (div_wr == '0) ? hemaia_clk_pkg::DivWidth'(1) : div_wr;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  // Writes and unmapped offsets read back 0
  always_comb begin
    rd_word = '0;
    if (!bus.write) begin
      if (bus.offset == hemaia_map_pkg::RegDivOffset) begin
        rd_word = {{(hemaia_map_pkg::DataWidth - hemaia_clk_pkg::DivWidth){1'b0}}, div_q};
      end else if (bus.offset == hemaia_map_pkg::RegChipIdOffset) begin
        rd_word = {{(hemaia_map_pkg::DataWidth - hemaia_map_pkg::ChipIdWidth){1'b0}},
                   chip_id_i};
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= rd_word;
    end
  end

  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rdata     = rdata_q;
  assign bus.error     = 1'b0;
  assign division_o    = div_q;

endmodule

`default_nettype wire

// File: logic/hemaia_mem_chip.sv
// Memory chip fabric on a single clock.
// One request outstanding at a time. Responses cannot be stalled.
// The top address byte must match the chip ID sampled during reset.

`timescale 1ns/1ps
`default_nettype none

module hemaia_mem_chip (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_ni,
  input  wire logic [hemaia_map_pkg::ChipIdWidth-1:0] chip_id_i,
  input  wire logic                                   req_valid_i,
  input  wire logic                                   req_write_i,
  input  wire logic [hemaia_map_pkg::AddrWidth-1:0]   req_addr_i,
  input  wire logic [hemaia_map_pkg::DataWidth-1:0]   req_wdata_i,
  output logic                                        req_ready_o,
  output logic                                        rsp_valid_o,
  output logic      [hemaia_map_pkg::DataWidth-1:0]   rsp_rdata_o,
  output logic                                        rsp_error_o
);

  logic                                   mem_tick;
  logic                                   mem_rst_n;
  logic [hemaia_clk_pkg::DivWidth-1:0]    division;
  logic [hemaia_map_pkg::ChipIdWidth-1:0] chip_id;

  hemaia_bus_if mem_bus ();
  hemaia_bus_if periph_bus ();

  hemaia_clk_rst_ctrl i_hemaia_clk_rst_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .division_i (division),
    .mem_tick_o (mem_tick),
    .mem_rst_no (mem_rst_n)
  );

  hemaia_addr_router i_hemaia_addr_router (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .chip_id_i   (chip_id_i),
    .req_valid_i (req_valid_i),
    .req_write_i (req_write_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_error_o (rsp_error_o),
    .chip_id_o   (chip_id),
    .mem_bus     (mem_bus),
    .periph_bus  (periph_bus)
  );

  hemaia_mem_bank i_hemaia_mem_bank (
    .clk_i      (clk_i),
    .mem_tick_i (mem_tick),
    .mem_rst_ni (mem_rst_n),
    .bus        (mem_bus)
  );

  hemaia_periph_regs i_hemaia_periph_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .chip_id_i  (chip_id),
    .division_o (division),
    .bus        (periph_bus)
  );

endmodule

`default_nettype wire

// File: testbench/tb_mem_chip_model.svh
// Reference model of the memory chip, included inside the testbench module.
// Memory words never written read as 0. The chip ID is the one held during reset.
// Requests are predicted one at a time, in issue order.

`ifndef TB_MEM_CHIP_MODEL_SVH
`define TB_MEM_CHIP_MODEL_SVH

// Sparse memory keyed by word index
logic [31:0] model_mem [int unsigned];
logic [7:0]  model_div;
logic [7:0]  model_chip_id;

function automatic void reset_model(input logic [7:0] chip_id);
  model_mem.delete();
  model_div     = 8'd4;
  model_chip_id = chip_id;
endfunction

function automatic void predict_response(
  input  logic        write,
  input  logic [47:0] addr,
  input  logic [31:0] wdata,
  output logic [31:0] rdata,
  output logic        error
);
  logic [39:0] local_addr;
  logic [39:0] offset;
  int unsigned word;
  rdata      = '0;
  error      = 1'b0;
  local_addr = addr[39:0];
  if (addr[47:40] != model_chip_id) begin
    error = 1'b1;
  end else if (local_addr >= hemaia_map_pkg::MemBase &&
               local_addr < hemaia_map_pkg::MemBase + hemaia_map_pkg::MemSize) begin
    offset = local_addr - hemaia_map_pkg::MemBase;
    word   = {22'd0, offset[11:2]};
    if (write) begin
      model_mem[word] = wdata;
    end else if (model_mem.exists(word)) begin
      rdata = model_mem[word];
    end
  end else if (local_addr >= hemaia_map_pkg::PeriphBase &&
               local_addr < hemaia_map_pkg::PeriphBase + hemaia_map_pkg::PeriphSize) begin
    offset = local_addr - hemaia_map_pkg::PeriphBase;
    if (write) begin
      // A written 0 is kept as 1
      if (offset == 40'h0) begin
        model_div = (wdata[7:0] == 8'd0) ? 8'd1 : wdata[7:0];
      end
    end else if (offset == 40'h0) begin
      rdata = {24'd0, model_div};
    end else if (offset == 40'h4) begin
      rdata = {24'd0, model_chip_id};
    end
  end else begin
    error = 1'b1;
  end
endfunction

`endif

// File: testbench/tb_hemaia_mem_chip.sv
// Testbench for the memory chip fabric, random requests from a fixed seed.
// Each response is compared with the model in tb_mem_chip_model.svh.
// Inputs change 2 ns after the rising edge, outputs are sampled at the falling edge.

`timescale 1ns/1ps
`default_nettype none

module tb_hemaia_mem_chip;

  localparam int unsigned NumRequests = 300;
  localparam int unsigned ClkPeriod   = 40;
  // Largest divisor, reset delay and handshake overhead for every request
  localparam int unsigned WatchdogNs  = NumRequests * (255 + 3 + 4) * ClkPeriod;

  logic        clk_i;
  logic        rst_ni;
  logic [7:0]  chip_id_i;
  logic        req_valid_i;
  logic        req_write_i;
  logic [47:0] req_addr_i;
  logic [31:0] req_wdata_i;
  logic        req_ready_o;
  logic        rsp_valid_o;
  logic [31:0] rsp_rdata_o;
  logic        rsp_error_o;
  integer      seed;

  `include "tb_mem_chip_model.svh"

  hemaia_mem_chip dut0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .chip_id_i   (chip_id_i),
    .req_valid_i (req_valid_i),
    .req_write_i (req_write_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_error_o (rsp_error_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("Test FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic pick_request(output logic write, output logic [47:0] addr,
                              output logic [31:0] wdata);
    logic [31:0] r;
    logic [31:0] pick;
    logic [9:0]  word;
    logic [7:0]  other_id;
    r        = $random(seed);
    pick     = $random(seed);
    wdata    = $random(seed);
    write    = r[31];
    // Mostly a small set of words, so reads hit earlier writes
    word     = r[20] ? r[9:0] : {6'd0, r[3:0]};
    other_id = (r[15:8] == 8'h5A) ? 8'hC3 : r[15:8];
    case (pick % 32'd10)
      0, 1, 2, 3, 4: addr = {8'h5A, hemaia_map_pkg::MemBase + {28'd0, word, 2'b00}};
      5: addr = {r[16] ? 8'hC3 : other_id, hemaia_map_pkg::MemBase + {28'd0, word, 2'b00}};
      6: begin
        case (r[17:16])
          2'd0: addr = {8'h5A, hemaia_map_pkg::MemBase + hemaia_map_pkg::MemSize
                               + {28'd0, word, 2'b00}};
          2'd1: addr = {8'h5A, hemaia_map_pkg::PeriphBase - 40'd4};
          2'd2: addr = {8'h5A, hemaia_map_pkg::PeriphBase + hemaia_map_pkg::PeriphSize};
          default: addr = {8'h5A, r[7:0], pick};
        endcase
      end
      7: begin
        write = r[31] & r[30];
        addr  = {8'h5A, hemaia_map_pkg::PeriphBase + hemaia_map_pkg::RegChipIdOffset};
      end
      8: begin
        write = 1'b1;
        addr  = {8'h5A, hemaia_map_pkg::PeriphBase + hemaia_map_pkg::RegDivOffset};
        if (r[26:24] == 3'd0) begin
          wdata = {wdata[31:8], 8'h00};
        end
      end
      default: begin
        write = 1'b0;
        addr  = {8'h5A, hemaia_map_pkg::PeriphBase +
                        (r[17] ? hemaia_map_pkg::RegDivOffset : {28'd0, word, 2'b00})};
      end
    endcase
  endtask

  // One full transfer, with handshake checks on every cycle
  task automatic run_request(input logic write, input logic [47:0] addr,
                             input logic [31:0] wdata);
    logic [31:0] exp_rdata;
    logic        exp_error;
    predict_response(write, addr, wdata, exp_rdata, exp_error);
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b1;
    req_write_i = write;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    @(negedge clk_i);
    while (!req_ready_o) begin
      check_value("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
      @(negedge clk_i);
    end
    check_value("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b0;
    @(negedge clk_i);
    while (!rsp_valid_o) begin
      check_value("req_ready_o", 32'(req_ready_o), 32'd0);
      @(negedge clk_i);
    end
    check_value("req_ready_o", 32'(req_ready_o), 32'd0);
    check_value("rsp_rdata_o", rsp_rdata_o, exp_rdata);
    check_value("rsp_error_o", 32'(rsp_error_o), 32'(exp_error));
    // Pulse lasts one cycle and the router is idle again
    @(negedge clk_i);
    check_value("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
    check_value("req_ready_o", 32'(req_ready_o), 32'd1);
  endtask

  initial begin
    logic        write;
    logic [47:0] addr;
    logic [31:0] wdata;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    chip_id_i   = 8'h5A;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    seed        = 32'h7670;
    reset_model(8'h5A);
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni    = 1'b1;
    // Pin changes, the latched ID must not
    chip_id_i = 8'hC3;
    @(negedge clk_i);
    check_value("req_ready_o", 32'(req_ready_o), 32'd1);
    check_value("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
    for (int unsigned i = 0; i < NumRequests; i++) begin
      pick_request(write, addr, wdata);
      run_request(write, addr, wdata);
    end
    $display("Test OK");
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns, responses stopped arriving", WatchdogNs);
    $display("Test FAILED");
    $fatal(1, "Simulation timed out");
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+testbench
logic/hemaia_map_pkg.sv
logic/hemaia_clk_pkg.sv
logic/hemaia_bus_if.sv
logic/hemaia_clk_rst_ctrl.sv
logic/hemaia_addr_router.sv
logic/hemaia_mem_bank.sv
logic/hemaia_periph_regs.sv
logic/hemaia_mem_chip.sv
testbench/tb_hemaia_mem_chip.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is nonzero when the build fails or the simulation stops on $fatal.

cd "$(dirname "$0")" \
  && verilator --binary --timing -j 0 --top-module tb_hemaia_mem_chip -f compile.f \
  && ./obj_dir/Vtb_hemaia_mem_chip \
  || { echo "Simulation build or run failed"; exit 1; }
